// File: verilog/xbar_pkg.sv
package xbar_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int addr_w     = 32;
	localparam int data_w     = 32;        // Requester side
	localparam int bus_data_w = 64;        // SoC AXI4 side
	localparam int id_w       = 4;
	localparam int len_w      = 8;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Response codes and sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	localparam logic [2:0] size_word = 3'd2;   // 4 bytes, used by every fetch

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CLINT window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [addr_w-1:0] clint_base_default = 32'h0200_0000;
	localparam logic [addr_w-1:0] clint_size         = 32'h0001_0000;   // 64 KiB

	localparam logic [addr_w-1:0] mtime_lo_off = 32'h0000_bff8;
	localparam logic [addr_w-1:0] mtime_hi_off = 32'h0000_bffc;

endpackage

// File: verilog/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter (
	input  logic clock,
	input  logic rst,
	input  logic ifu_arvalid,
	input  logic lsu_arvalid,
	input  logic ifu_r_done,
	input  logic lsu_r_done,
	output logic ifu_owner,
	output logic lsu_owner
);

	typedef enum logic [1:0] {
		st_idle,
		st_ifu,
		st_lsu
	} state_t;

	state_t state;
	state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (ifu_arvalid)                    // IFU has priority
					state_next = st_ifu;
				else if (lsu_arvalid)
					state_next = st_lsu;
			end
			st_ifu: begin
				if (ifu_r_done)
					state_next = st_idle;
			end
			st_lsu: begin
				if (lsu_r_done)
					state_next = st_idle;
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst)
			state <= st_idle;
		else
			state <= state_next;
	end

	assign ifu_owner = (state == st_ifu);
	assign lsu_owner = (state == st_lsu);

	a_one_owner: assert property (@(posedge clock) disable iff (rst)
		!(ifu_owner && lsu_owner));
	a_ifu_hold: assert property (@(posedge clock) disable iff (rst)
		ifu_owner && !ifu_r_done |=> ifu_owner);
	a_lsu_hold: assert property (@(posedge clock) disable iff (rst)
		lsu_owner && !lsu_r_done |=> lsu_owner);

endmodule

// File: verilog/xbar.sv
`timescale 1ns/1ps

module xbar #(
	parameter logic [xbar_pkg::addr_w-1:0] clint_base = xbar_pkg::clint_base_default
) (
	input  logic                               clock,
	input  logic                               rst,

	input  logic [xbar_pkg::addr_w-1:0]        ifu_araddr,
	input  logic                               ifu_arvalid,
	output logic                               ifu_arready,
	output logic [xbar_pkg::data_w-1:0]        ifu_rdata,
	output logic [1:0]                         ifu_rresp,
	output logic                               ifu_rvalid,
	input  logic                               ifu_rready,

	input  logic [xbar_pkg::addr_w-1:0]        lsu_araddr,
	input  logic                               lsu_arvalid,
	input  logic [2:0]                         lsu_arsize,
	output logic                               lsu_arready,
	output logic [xbar_pkg::data_w-1:0]        lsu_rdata,
	output logic [1:0]                         lsu_rresp,
	output logic                               lsu_rvalid,
	input  logic                               lsu_rready,
	input  logic [xbar_pkg::addr_w-1:0]        lsu_awaddr,
	input  logic                               lsu_awvalid,
	input  logic [2:0]                         lsu_awsize,
	output logic                               lsu_awready,
	input  logic [xbar_pkg::data_w-1:0]        lsu_wdata,
	input  logic [xbar_pkg::data_w/8-1:0]      lsu_wstrb,
	input  logic                               lsu_wvalid,
	output logic                               lsu_wready,
	output logic [1:0]                         lsu_bresp,
	output logic                               lsu_bvalid,
	input  logic                               lsu_bready,

	input  logic                               io_master_awready,
	output logic                               io_master_awvalid,
	output logic [xbar_pkg::addr_w-1:0]        io_master_awaddr,
	output logic [xbar_pkg::id_w-1:0]          io_master_awid,
	output logic [xbar_pkg::len_w-1:0]         io_master_awlen,
	output logic [2:0]                         io_master_awsize,
	output logic [1:0]                         io_master_awburst,
	input  logic                               io_master_wready,
	output logic                               io_master_wvalid,
	output logic [xbar_pkg::bus_data_w-1:0]    io_master_wdata,
	output logic [xbar_pkg::bus_data_w/8-1:0]  io_master_wstrb,
	output logic                               io_master_wlast,
	output logic                               io_master_bready,
	input  logic                               io_master_bvalid,
	input  logic [1:0]                         io_master_bresp,
	input  logic [xbar_pkg::id_w-1:0]          io_master_bid,
	input  logic                               io_master_arready,
	output logic                               io_master_arvalid,
	output logic [xbar_pkg::addr_w-1:0]        io_master_araddr,
	output logic [xbar_pkg::id_w-1:0]          io_master_arid,
	output logic [xbar_pkg::len_w-1:0]         io_master_arlen,
	output logic [2:0]                         io_master_arsize,
	output logic [1:0]                         io_master_arburst,
	output logic                               io_master_rready,
	input  logic                               io_master_rvalid,
	input  logic [1:0]                         io_master_rresp,
	input  logic [xbar_pkg::bus_data_w-1:0]    io_master_rdata,
	input  logic                               io_master_rlast,
	input  logic [xbar_pkg::id_w-1:0]          io_master_rid,

	output logic [xbar_pkg::addr_w-1:0]        clint_araddr,
	output logic                               clint_arvalid,
	input  logic                               clint_arready,
	input  logic [xbar_pkg::data_w-1:0]        clint_rdata,
	input  logic [1:0]                         clint_rresp,
	input  logic                               clint_rvalid,
	output logic                               clint_rready
);

	logic                        ifu_owner, lsu_owner;
	logic                        ifu_r_done, lsu_r_done;
	logic                        ar_busy;             // AR accepted, R outstanding
	logic                        lsu_clint_q;
	logic                        lsu_in_clint, lsu_use_clint;
	logic                        ifu_ar_go, lsu_ar_go;
	logic [xbar_pkg::addr_w-1:0] lsu_off;

	read_arbiter read_arbiter_i (
		.clock       (clock),
		.rst         (rst),
		.ifu_arvalid (ifu_arvalid),
		.lsu_arvalid (lsu_arvalid),
		.ifu_r_done  (ifu_r_done),
		.lsu_r_done  (lsu_r_done),
		.ifu_owner   (ifu_owner),
		.lsu_owner   (lsu_owner)
	);

	// Unsigned wrap covers both window bounds
	assign lsu_off       = lsu_araddr - clint_base;
	assign lsu_in_clint  = (lsu_off < xbar_pkg::clint_size);
	assign lsu_use_clint = ar_busy ? lsu_clint_q : lsu_in_clint;   // Route held until R

	always_ff @(posedge clock) begin
		if (rst) begin
			ar_busy     <= 1'b0;
			lsu_clint_q <= 1'b0;
		end else if (ifu_r_done || lsu_r_done) begin
			ar_busy <= 1'b0;
		end else if (ifu_arvalid && ifu_arready || lsu_arvalid && lsu_arready) begin
			ar_busy     <= 1'b1;
			lsu_clint_q <= lsu_in_clint;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read address and data
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign ifu_ar_go = ifu_owner && !ar_busy;
	assign lsu_ar_go = lsu_owner && !ar_busy;

	assign ifu_arready       = ifu_ar_go && io_master_arready;
	assign lsu_arready       = lsu_ar_go && (lsu_use_clint ? clint_arready : io_master_arready);
	assign io_master_arvalid = ifu_ar_go && ifu_arvalid ||
	                           lsu_ar_go && !lsu_use_clint && lsu_arvalid;
	assign io_master_araddr  = ifu_owner ? ifu_araddr : lsu_araddr;
	assign io_master_arsize  = ifu_owner ? xbar_pkg::size_word : lsu_arsize;
	assign io_master_arid    = '0;
	assign io_master_arlen   = '0;
	assign io_master_arburst = '0;
	assign clint_arvalid     = lsu_ar_go && lsu_use_clint && lsu_arvalid;
	assign clint_araddr      = lsu_araddr;

	assign ifu_rvalid       = ifu_owner && ar_busy && io_master_rvalid;
	assign lsu_rvalid       = lsu_owner && ar_busy && (lsu_use_clint ? clint_rvalid : io_master_rvalid);
	assign io_master_rready = ifu_owner && ar_busy && ifu_rready ||
	                          lsu_owner && ar_busy && !lsu_use_clint && lsu_rready;
	assign clint_rready     = lsu_owner && ar_busy && lsu_use_clint && lsu_rready;
	assign ifu_rdata        = io_master_rdata[xbar_pkg::data_w-1:0];   // Low lane
	assign ifu_rresp        = io_master_rresp;
	assign lsu_rdata        = lsu_use_clint ? clint_rdata : io_master_rdata[xbar_pkg::data_w-1:0];
	assign lsu_rresp        = lsu_use_clint ? clint_rresp : io_master_rresp;

	assign ifu_r_done = ifu_rvalid && ifu_rready;
	assign lsu_r_done = lsu_rvalid && lsu_rready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lsu_awready       = io_master_awready;
	assign io_master_awvalid = lsu_awvalid;
	assign io_master_awaddr  = lsu_awaddr;
	assign io_master_awsize  = lsu_awsize;
	assign io_master_awid    = '0;
	assign io_master_awlen   = '0;
	assign io_master_awburst = '0;

	assign lsu_wready       = io_master_wready;
	assign io_master_wvalid = lsu_wvalid;
	assign io_master_wdata  = {{(xbar_pkg::bus_data_w - xbar_pkg::data_w){1'b0}}, lsu_wdata};
	assign io_master_wstrb  = {{((xbar_pkg::bus_data_w - xbar_pkg::data_w) / 8){1'b0}}, lsu_wstrb};
	assign io_master_wlast  = io_master_wvalid;   // Single beat

	assign io_master_bready = lsu_bready;
	assign lsu_bvalid       = io_master_bvalid;
	assign lsu_bresp        = io_master_bresp;

	a_one_target: assert property (@(posedge clock) disable iff (rst)
		!(io_master_arvalid && clint_arvalid));
	// SoC answers single beats on ID 0 only
	a_soc_rbeat: assert property (@(posedge clock) disable iff (rst)
		io_master_rvalid |-> io_master_rlast && io_master_rid == '0);
	a_soc_bid: assert property (@(posedge clock) disable iff (rst)
		io_master_bvalid |-> io_master_bid == '0);

endmodule

// File: verilog/clint.sv
`timescale 1ns/1ps

module clint #(
	parameter logic [xbar_pkg::addr_w-1:0] clint_base = xbar_pkg::clint_base_default
) (
	input  logic                        clock,
	input  logic                        rst,
	input  logic [xbar_pkg::addr_w-1:0] araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [xbar_pkg::data_w-1:0] rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready
);

	logic [63:0]                 mtime;
	logic [xbar_pkg::addr_w-1:0] off;

	assign off     = araddr - clint_base;
	assign arready = !rvalid;   // Idle when no response is pending

	always_ff @(posedge clock) begin
		if (rst)
			mtime <= '0;
		else
			mtime <= mtime + 64'd1;
	end

	always_ff @(posedge clock) begin
		if (rst)
			rvalid <= 1'b0;
		else if (arvalid && arready)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// Snapshot of the addressed half
	always_ff @(posedge clock) begin
		if (arvalid && arready) begin
			case (off)
				xbar_pkg::mtime_lo_off: begin
					rdata <= mtime[31:0];
					rresp <= xbar_pkg::resp_okay;
				end
				xbar_pkg::mtime_hi_off: begin
					rdata <= mtime[63:32];
					rresp <= xbar_pkg::resp_okay;
				end
				default: begin
					rdata <= '0;
					rresp <= xbar_pkg::resp_slverr;
				end
			endcase
		end
	end

	a_r_hold: assert property (@(posedge clock) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// File: verilog/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
	parameter logic [xbar_pkg::addr_w-1:0] clint_base = xbar_pkg::clint_base_default
) (
	input  logic                               clock,
	input  logic                               rst,

	input  logic [xbar_pkg::addr_w-1:0]        ifu_araddr,
	input  logic                               ifu_arvalid,
	output logic                               ifu_arready,
	output logic [xbar_pkg::data_w-1:0]        ifu_rdata,
	output logic [1:0]                         ifu_rresp,
	output logic                               ifu_rvalid,
	input  logic                               ifu_rready,

	input  logic [xbar_pkg::addr_w-1:0]        lsu_araddr,
	input  logic                               lsu_arvalid,
	input  logic [2:0]                         lsu_arsize,
	output logic                               lsu_arready,
	output logic [xbar_pkg::data_w-1:0]        lsu_rdata,
	output logic [1:0]                         lsu_rresp,
	output logic                               lsu_rvalid,
	input  logic                               lsu_rready,
	input  logic [xbar_pkg::addr_w-1:0]        lsu_awaddr,
	input  logic                               lsu_awvalid,
	input  logic [2:0]                         lsu_awsize,
	output logic                               lsu_awready,
	input  logic [xbar_pkg::data_w-1:0]        lsu_wdata,
	input  logic [xbar_pkg::data_w/8-1:0]      lsu_wstrb,
	input  logic                               lsu_wvalid,
	output logic                               lsu_wready,
	output logic [1:0]                         lsu_bresp,
	output logic                               lsu_bvalid,
	input  logic                               lsu_bready,

	input  logic                               io_master_awready,
	output logic                               io_master_awvalid,
	output logic [xbar_pkg::addr_w-1:0]        io_master_awaddr,
	output logic [xbar_pkg::id_w-1:0]          io_master_awid,
	output logic [xbar_pkg::len_w-1:0]         io_master_awlen,
	output logic [2:0]                         io_master_awsize,
	output logic [1:0]                         io_master_awburst,
	input  logic                               io_master_wready,
	output logic                               io_master_wvalid,
	output logic [xbar_pkg::bus_data_w-1:0]    io_master_wdata,
	output logic [xbar_pkg::bus_data_w/8-1:0]  io_master_wstrb,
	output logic                               io_master_wlast,
	output logic                               io_master_bready,
	input  logic                               io_master_bvalid,
	input  logic [1:0]                         io_master_bresp,
	input  logic [xbar_pkg::id_w-1:0]          io_master_bid,
	input  logic                               io_master_arready,
	output logic                               io_master_arvalid,
	output logic [xbar_pkg::addr_w-1:0]        io_master_araddr,
	output logic [xbar_pkg::id_w-1:0]          io_master_arid,
	output logic [xbar_pkg::len_w-1:0]         io_master_arlen,
	output logic [2:0]                         io_master_arsize,
	output logic [1:0]                         io_master_arburst,
	output logic                               io_master_rready,
	input  logic                               io_master_rvalid,
	input  logic [1:0]                         io_master_rresp,
	input  logic [xbar_pkg::bus_data_w-1:0]    io_master_rdata,
	input  logic                               io_master_rlast,
	input  logic [xbar_pkg::id_w-1:0]          io_master_rid
);

	logic [xbar_pkg::addr_w-1:0] clint_araddr;
	logic                        clint_arvalid;
	logic                        clint_arready;
	logic [xbar_pkg::data_w-1:0] clint_rdata;
	logic [1:0]                  clint_rresp;
	logic                        clint_rvalid;
	logic                        clint_rready;

	xbar #(
		.clint_base (clint_base)
	) xbar_i (.*);   // Port names match one to one

	clint #(
		.clint_base (clint_base)
	) clint_i (
		.clock   (clock),
		.rst     (rst),
		.araddr  (clint_araddr),
		.arvalid (clint_arvalid),
		.arready (clint_arready),
		.rdata   (clint_rdata),
		.rresp   (clint_rresp),
		.rvalid  (clint_rvalid),
		.rready  (clint_rready)
	);

endmodule

// File: sim/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
	parameter int depth = 1024
) (
	input  logic        clock,
	input  logic        rst,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	output logic [3:0]  bid,
	input  logic        arvalid,
	output logic        arready,
	input  logic [31:0] araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rlast,
	output logic [3:0]  rid
);

	localparam int idx_w = $clog2(depth);

	logic [31:0] mem [depth];
	logic        written [depth];
	logic [31:0] aw_addr_q;
	logic [31:0] w_data_q;
	logic [3:0]  w_strb_q;
	logic        aw_got, w_got;

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		if (written[addr[idx_w+1:2]])
			return mem[addr[idx_w+1:2]];
		return addr ^ 32'ha5a5a5a5;   // Fill for untouched words
	endfunction

	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8*b +: 8] = data[8*b +: 8];
		return res;
	endfunction

	assign awready = !aw_got && !bvalid;
	assign wready  = !w_got && !bvalid;
	assign arready = !rvalid;
	assign bresp   = 2'b00;
	assign rresp   = 2'b00;
	assign bid     = '0;
	assign rid     = '0;
	assign rlast   = 1'b1;   // Single beats only

	always_ff @(posedge clock) begin
		if (rst) begin
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			bvalid  <= 1'b0;
			rvalid  <= 1'b0;
			written <= '{default: 1'b0};
		end else begin
			if (awvalid && awready) begin
				aw_got    <= 1'b1;
				aw_addr_q <= awaddr;
			end
			if (wvalid && wready) begin
				w_got    <= 1'b1;
				w_data_q <= wdata[31:0];
				w_strb_q <= wstrb[3:0];
			end
			if (aw_got && w_got) begin
				mem[aw_addr_q[idx_w+1:2]]     <= merge(word_at(aw_addr_q), w_data_q, w_strb_q);
				written[aw_addr_q[idx_w+1:2]] <= 1'b1;
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (arvalid && arready) begin
				rvalid <= 1'b1;
				rdata  <= {32'h0, word_at(araddr)};   // Low lane
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

// File: sim/xbar_checker.sv
`timescale 1ns/1ps

module xbar_checker #(
	parameter logic [31:0] clint_base = 32'h0200_0000
) (
	input  logic        clock,
	input  logic        rst,
	input  int          test_id,
	input  logic        test_end,
	input  logic [31:0] ifu_araddr,
	input  logic        ifu_arvalid,
	input  logic        ifu_arready,
	input  logic [31:0] ifu_rdata,
	input  logic [1:0]  ifu_rresp,
	input  logic        ifu_rvalid,
	input  logic        ifu_rready,
	input  logic [31:0] lsu_araddr,
	input  logic        lsu_arvalid,
	input  logic        lsu_arready,
	input  logic [31:0] lsu_rdata,
	input  logic [1:0]  lsu_rresp,
	input  logic        lsu_rvalid,
	input  logic        lsu_rready,
	input  logic [31:0] lsu_awaddr,
	input  logic        lsu_awvalid,
	input  logic        lsu_awready,
	input  logic [2:0]  lsu_awsize,
	input  logic [31:0] lsu_wdata,
	input  logic [3:0]  lsu_wstrb,
	input  logic        lsu_wvalid,
	input  logic        lsu_wready,
	input  logic [1:0]  lsu_bresp,
	input  logic        lsu_bvalid,
	input  logic        lsu_bready,
	input  logic        io_master_arvalid,
	input  logic        io_master_arready,
	input  logic [2:0]  io_master_arsize,
	input  logic [3:0]  io_master_arid,
	input  logic [7:0]  io_master_arlen,
	input  logic [1:0]  io_master_arburst,
	input  logic [3:0]  io_master_awid,
	input  logic [7:0]  io_master_awlen,
	input  logic [2:0]  io_master_awsize,
	input  logic [1:0]  io_master_awburst,
	input  logic [63:0] io_master_wdata,
	input  logic [7:0]  io_master_wstrb,
	input  logic        io_master_wlast,
	input  logic        clint_arvalid,
	output int          errors,
	output int          checks
);

	logic [31:0] shadow [logic [31:0]];   // Word image of the SoC memory
	logic [31:0] ifu_addr_q, lsu_addr_q, aw_addr_q, w_data_q, last_mtime;
	logic [3:0]  w_strb_q;
	logic        aw_seen, w_seen, mtime_seen;
	logic [33:0] want;
	int          test_checks, test_errors;

	function automatic string test_name(input int id);
		case (id)
			1: return "ifu_fetch";
			2: return "lsu_write_read";
			3: return "concurrent_read";
			4: return "mtime_read";
			5: return "clint_bad_offset";
			6: return "rready_backpressure";
			default: return "reset";
		endcase
	endfunction

	function automatic logic in_clint(input logic [31:0] addr);
		return addr >= clint_base && addr <= clint_base + xbar_pkg::clint_size - 32'd1;
	endfunction

	function automatic logic [31:0] stored_word(input logic [31:0] addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return addr ^ 32'ha5a5a5a5;
	endfunction

	// Expected {rresp, rdata} of one read
	function automatic logic [33:0] expected_read(input logic [31:0] addr, input logic from_lsu);
		logic [31:0] off;
		off = addr - clint_base;
		if (from_lsu && in_clint(addr)) begin
			if (off == xbar_pkg::mtime_lo_off || off == xbar_pkg::mtime_hi_off)
				return {xbar_pkg::resp_okay, 32'h0};
			return {xbar_pkg::resp_slverr, 32'h0};
		end
		return {xbar_pkg::resp_okay, stored_word(addr)};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8*b +: 8] = data[8*b +: 8];
		return res;
	endfunction

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		test_checks++;
		checks++;
		if (exp !== act) begin
			test_errors++;
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", test_name(test_id), what, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		test_errors++;
		errors++;
		$display("Error in %s: %s", test_name(test_id), msg);
	endtask

	always @(posedge clock) begin
		if (rst) begin
			aw_seen     = 1'b0;
			w_seen      = 1'b0;
			mtime_seen  = 1'b0;
			errors      = 0;
			checks      = 0;
			test_checks = 0;
			test_errors = 0;
		end else begin
			if (io_master_arvalid && clint_arvalid)
				report_error("SoC and CLINT read addresses were valid together");

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Address phases
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			if (ifu_arvalid && ifu_arready) begin
				ifu_addr_q = ifu_araddr;
				compare("fetch arsize", 32'(xbar_pkg::size_word), 32'(io_master_arsize));
			end
			if (lsu_arvalid && lsu_arready) begin
				lsu_addr_q = lsu_araddr;
				if (test_id == 3 && ifu_arvalid)
					report_error("LSU read was accepted ahead of a waiting IFU fetch");
				if (in_clint(lsu_araddr) && io_master_arvalid)
					report_error("CLINT read address showed up on the SoC bus");
			end
			if (io_master_arvalid && io_master_arready)
				compare("SoC ar id/len/burst", 32'h0,
					32'({io_master_arid, io_master_arlen, io_master_arburst}));
			if (lsu_awvalid && lsu_awready) begin
				aw_addr_q = lsu_awaddr;
				aw_seen   = 1'b1;
				compare("SoC aw id/len/burst", 32'h0,
					32'({io_master_awid, io_master_awlen, io_master_awburst}));
				compare("SoC awsize", 32'(lsu_awsize), 32'(io_master_awsize));
			end
			if (lsu_wvalid && lsu_wready) begin
				w_data_q = lsu_wdata;
				w_strb_q = lsu_wstrb;
				w_seen   = 1'b1;
				compare("SoC wdata high lane", 32'h0, io_master_wdata[63:32]);
				compare("SoC wstrb", 32'(lsu_wstrb), 32'(io_master_wstrb));
				compare("SoC wlast", 32'h1, 32'(io_master_wlast));
			end
			if (aw_seen && w_seen) begin
				shadow[aw_addr_q] = merge_bytes(stored_word(aw_addr_q), w_data_q, w_strb_q);
				aw_seen = 1'b0;
				w_seen  = 1'b0;
			end

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Responses
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			if (ifu_rvalid && ifu_rready) begin
				want = expected_read(ifu_addr_q, 1'b0);
				compare("fetch rresp", 32'(want[33:32]), 32'(ifu_rresp));
				compare("fetch rdata", want[31:0], ifu_rdata);
			end
			if (lsu_rvalid && lsu_rready) begin
				want = expected_read(lsu_addr_q, 1'b1);
				compare("load rresp", 32'(want[33:32]), 32'(lsu_rresp));
				if (lsu_addr_q - clint_base == xbar_pkg::mtime_lo_off) begin
					if (mtime_seen && lsu_rdata <= last_mtime)
						report_error($sformatf("mtime did not increase, %h then %h",
							last_mtime, lsu_rdata));
					last_mtime = lsu_rdata;
					mtime_seen = 1'b1;
				end else if (lsu_addr_q - clint_base != xbar_pkg::mtime_hi_off) begin
					compare("load rdata", want[31:0], lsu_rdata);
				end
			end
			if (lsu_bvalid && lsu_bready)
				compare("store bresp", 32'(xbar_pkg::resp_okay), 32'(lsu_bresp));

			if (test_end) begin
				$display("test %s: %0d checks, %0d errors", test_name(test_id),
					test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
			end
		end
	end

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ps

module tb_top;

	localparam logic [31:0] clint_base = xbar_pkg::clint_base_default;
	localparam int          wait_limit = 200;

	logic        clock, rst;
	logic [31:0] ifu_araddr, ifu_rdata, lsu_araddr, lsu_rdata, lsu_awaddr, lsu_wdata;
	logic        ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic        lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic        lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
	logic [1:0]  ifu_rresp, lsu_rresp, lsu_bresp;
	logic [2:0]  lsu_arsize, lsu_awsize;
	logic [3:0]  lsu_wstrb;
	logic        io_master_awready, io_master_awvalid, io_master_wready, io_master_wvalid;
	logic        io_master_wlast, io_master_bready, io_master_bvalid;
	logic        io_master_arready, io_master_arvalid, io_master_rready, io_master_rvalid;
	logic        io_master_rlast;
	logic [31:0] io_master_awaddr, io_master_araddr;
	logic [63:0] io_master_wdata, io_master_rdata;
	logic [7:0]  io_master_wstrb, io_master_awlen, io_master_arlen;
	logic [3:0]  io_master_awid, io_master_bid, io_master_arid, io_master_rid;
	logic [2:0]  io_master_awsize, io_master_arsize;
	logic [1:0]  io_master_awburst, io_master_bresp, io_master_arburst, io_master_rresp;
	logic        clint_arvalid, test_end;
	logic [15:0] lfsr_state = 16'd90;
	logic [31:0] addrs [6];
	int          test_id, tests_run, errors, checks;

	mem_subsys_top #(.clint_base(clint_base)) mem_subsys_top_i (.*);

	assign clint_arvalid = mem_subsys_top_i.clint_arvalid;   // CLINT request inside the DUT

	axi_mem_model soc_mem (
		.clock   (clock),
		.rst     (rst),
		.awvalid (io_master_awvalid),
		.awready (io_master_awready),
		.awaddr  (io_master_awaddr),
		.wvalid  (io_master_wvalid),
		.wready  (io_master_wready),
		.wdata   (io_master_wdata),
		.wstrb   (io_master_wstrb),
		.bvalid  (io_master_bvalid),
		.bready  (io_master_bready),
		.bresp   (io_master_bresp),
		.bid     (io_master_bid),
		.arvalid (io_master_arvalid),
		.arready (io_master_arready),
		.araddr  (io_master_araddr),
		.rvalid  (io_master_rvalid),
		.rready  (io_master_rready),
		.rdata   (io_master_rdata),
		.rresp   (io_master_rresp),
		.rlast   (io_master_rlast),
		.rid     (io_master_rid)
	);

	xbar_checker #(.clint_base(clint_base)) xbar_checker_i (.*);

	always #10 clock = ~clock;

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			val        = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] soc_address();
		return 32'h8000_0000 | (random_bits(10) << 2);   // Stays inside the model depth
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic fetch(input logic [31:0] addr);
		int n;
		@(negedge clock);
		ifu_araddr  = addr;
		ifu_arvalid = 1'b1;
		for (n = 0; n < wait_limit; n++) begin
			@(posedge clock);
			if (ifu_arready)
				break;
		end
		if (n == wait_limit)
			stop_on_timeout("IFU read address was never accepted");
		@(negedge clock);
		ifu_arvalid = 1'b0;
		for (n = 0; n < wait_limit; n++) begin
			@(posedge clock);
			if (ifu_rvalid)
				break;
		end
		if (n == wait_limit)
			stop_on_timeout("IFU read data never arrived");
	endtask

	task automatic load(input logic [31:0] addr, input logic stall);
		int n;
		@(negedge clock);
		lsu_araddr  = addr;
		lsu_arvalid = 1'b1;
		for (n = 0; n < wait_limit; n++) begin
			@(posedge clock);
			if (lsu_arready)
				break;
		end
		if (n == wait_limit)
			stop_on_timeout("LSU read address was never accepted");
		@(negedge clock);
		lsu_arvalid = 1'b0;
		for (n = 0; n < wait_limit; n++) begin
			if (stall)
				lsu_rready = (random_bits(2) == 32'd0);   // Mostly low
			@(posedge clock);
			if (lsu_rvalid && lsu_rready)
				break;
			@(negedge clock);
		end
		if (n == wait_limit)
			stop_on_timeout("LSU read data never arrived");
		@(negedge clock);
		lsu_rready = 1'b1;
	endtask

	task automatic store(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] strb);
		int   n;
		logic aw_taken, w_taken;
		@(negedge clock);
		lsu_awaddr  = addr;
		lsu_awvalid = 1'b1;
		lsu_wdata   = data;
		lsu_wstrb   = strb;
		lsu_wvalid  = 1'b1;
		for (n = 0; n < wait_limit && (lsu_awvalid || lsu_wvalid); n++) begin
			@(posedge clock);
			aw_taken = lsu_awvalid && lsu_awready;
			w_taken  = lsu_wvalid && lsu_wready;
			@(negedge clock);
			if (aw_taken)
				lsu_awvalid = 1'b0;
			if (w_taken)
				lsu_wvalid = 1'b0;
		end
		if (lsu_awvalid || lsu_wvalid)
			stop_on_timeout("LSU write address or data was never accepted");
		for (n = 0; n < wait_limit; n++) begin
			@(posedge clock);
			if (lsu_bvalid)
				break;
		end
		if (n == wait_limit)
			stop_on_timeout("LSU write response never arrived");
	endtask

	task automatic begin_test(input int id);
		@(negedge clock);
		test_id = id;
		tests_run++;
	endtask

	task automatic end_test();
		@(negedge clock);
		test_end = 1'b1;
		@(negedge clock);
		test_end = 1'b0;
	endtask

	initial begin
		logic [31:0] off;
		clock       = 1'b0;
		rst         = 1'b1;
		test_id     = 0;
		tests_run   = 0;
		test_end    = 1'b0;
		ifu_araddr  = '0;
		ifu_arvalid = 1'b0;
		ifu_rready  = 1'b1;
		lsu_araddr  = '0;
		lsu_arvalid = 1'b0;
		lsu_arsize  = xbar_pkg::size_word;
		lsu_rready  = 1'b1;
		lsu_awaddr  = '0;
		lsu_awvalid = 1'b0;
		lsu_awsize  = xbar_pkg::size_word;
		lsu_wdata   = '0;
		lsu_wstrb   = '0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;

		begin_test(1);
		for (int i = 0; i < 8; i++)
			fetch(soc_address());
		end_test();

		begin_test(2);
		for (int i = 0; i < 6; i++) begin
			addrs[i] = soc_address();
			store(addrs[i], random_bits(32), 4'(random_bits(4)));
		end
		for (int i = 0; i < 6; i++)
			load(addrs[i], 1'b0);
		end_test();

		// Every other load goes to the CLINT while the IFU holds the SoC
		begin_test(3);
		for (int i = 0; i < 4; i++) begin
			fork
				fetch(soc_address());
				load((i % 2 == 1) ? clint_base + xbar_pkg::mtime_lo_off : soc_address(), 1'b0);
			join
		end
		end_test();

		begin_test(4);
		for (int i = 0; i < 5; i++)
			load(clint_base + xbar_pkg::mtime_lo_off, 1'b0);
		end_test();

		begin_test(5);
		for (int i = 0; i < 5; i++) begin
			off = random_bits(14) << 2;
			if (off == xbar_pkg::mtime_lo_off || off == xbar_pkg::mtime_hi_off)
				off = 32'h0;
			load(clint_base + off, 1'b0);
		end
		end_test();

		begin_test(6);
		for (int i = 0; i < 6; i++)
			load(addrs[i], 1'b1);
		load(clint_base + xbar_pkg::mtime_lo_off, 1'b1);
		load(soc_address(), 1'b1);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: compile.f
verilog/xbar_pkg.sv
verilog/read_arbiter.sv
verilog/xbar.sv
verilog/clint.sv
verilog/mem_subsys_top.sv
sim/axi_mem_model.sv
sim/xbar_checker.sv
sim/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then judge the run from its log
verilator --binary --assert --top-module tb_top -f compile.f -o sim_tb_top \
	&& ./obj_dir/sim_tb_top > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
